//--- mul_rs_pkg.sv
`default_nettype none

package mul_rs_pkg;

    localparam int TAG_W     = 8;
    localparam int DATA_W    = 32;
    localparam int PC_W      = 32;
    localparam int NUM_BUSES = 4;

    // positions of the result buses in the bus arrays
    localparam int BUS_ALU  = 0;
    localparam int BUS_MUL  = 1;
    localparam int BUS_DIV  = 2;
    localparam int BUS_LOAD = 3;

    typedef logic [TAG_W-1:0]  tag_t;   // physical register tag
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PC_W-1:0]   pc_t;

endpackage

`default_nettype wire

//--- rs_select.sv
`timescale 1ns/100ps
`default_nettype none

module rs_select #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic [NUM_ENTRIES-1:0] ready,
    output logic [NUM_ENTRIES-1:0] grant
);

    logic found;    // a lower entry already took the grant

    // fixed priority, entry 0 highest
    always_comb begin
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            grant[i] = ready[i] & ~found;
            found    = found | ready[i];
        end
    end

endmodule

`default_nettype wire

//--- rs_operand_slot.sv
`timescale 1ns/100ps
`default_nettype none

module rs_operand_slot import mul_rs_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           alloc_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0] alloc_index,
    input  tag_t                           in_tag,
    input  data_t                          in_data,
    input  logic                           in_ready,
    input  logic [NUM_BUSES-1:0]           bus_valid,
    input  tag_t                           bus_tag [NUM_BUSES],
    input  data_t                          bus_data [NUM_BUSES],
    input  logic [NUM_ENTRIES-1:0]         clear,
    output logic [NUM_ENTRIES-1:0]         operand_valid,
    output data_t                          operand_data [NUM_ENTRIES]
);

    tag_t                   tag_q [NUM_ENTRIES];
    data_t                  data_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [NUM_ENTRIES-1:0] wait_q;     // allocated, still waiting on a tag
    logic [NUM_ENTRIES-1:0] alloc_sel;

    logic [DATA_W:0]        alloc_res;  // {hit, data} for the incoming operand
    logic                   alloc_valid;
    data_t                  alloc_data;
    logic [DATA_W:0]        wake_res [NUM_ENTRIES];

    // {hit, data} of the lowest-index valid bus carrying this tag
    function automatic logic [DATA_W:0] snoop(input tag_t tag);
        logic [DATA_W:0] res;
        res = '0;
        for (int b = NUM_BUSES - 1; b >= 0; b--) begin
            if (bus_valid[b] && bus_tag[b] == tag) begin
                res = {1'b1, bus_data[b]};
            end
        end
        return res;
    endfunction

    assign alloc_sel = {{(NUM_ENTRIES-1){1'b0}}, alloc_en} << alloc_index;

    always_comb begin
        alloc_res = snoop(in_tag);  // same-cycle bypass
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wake_res[i] = snoop(tag_q[i]);
        end
    end

    assign alloc_valid = in_ready | alloc_res[DATA_W];
    assign alloc_data  = in_ready ? in_data : alloc_res[DATA_W-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            wait_q  <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (alloc_sel[i]) begin
                    valid_q[i] <= alloc_valid;
                    wait_q[i]  <= ~alloc_valid;
                end else if (clear[i]) begin
                    valid_q[i] <= 1'b0;     // entry issued, slot free
                    wait_q[i]  <= 1'b0;
                end else if (wait_q[i] && wake_res[i][DATA_W]) begin
                    valid_q[i] <= 1'b1;
                    wait_q[i]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (alloc_sel[i]) begin
                tag_q[i]  <= in_tag;
                data_q[i] <= alloc_data;
            end else if (wait_q[i] && wake_res[i][DATA_W]) begin
                data_q[i] <= wake_res[i][DATA_W-1:0];
            end
        end
    end

    assign operand_valid = valid_q;
    assign operand_data  = data_q;

endmodule

`default_nettype wire

//--- mul_rs.sv
`timescale 1ns/100ps
`default_nettype none

module mul_rs import mul_rs_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic  clk,
    input  logic  reset,

    input  logic  alloc,
    input  pc_t   alloc_pc,
    input  tag_t  alloc_rd,
    input  tag_t  src1_tag,
    input  data_t src1_data,
    input  logic  src1_ready,
    input  tag_t  src2_tag,
    input  data_t src2_data,
    input  logic  src2_ready,

    input  data_t alu_result,
    input  tag_t  alu_dest,
    input  logic  alu_valid,
    input  data_t mul_result,
    input  tag_t  mul_dest,
    input  logic  mul_valid,
    input  data_t div_result,
    input  tag_t  div_dest,
    input  logic  div_valid,
    input  data_t load_result,
    input  tag_t  load_dest,
    input  logic  load_valid,

    output logic  issue_valid,
    output pc_t   issue_pc,
    output tag_t  issue_rd,
    output data_t issue_src1,
    output data_t issue_src2
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [IDX_W-1:0]       tail;
    pc_t                    pc_q [NUM_ENTRIES];
    tag_t                   rd_q [NUM_ENTRIES];

    logic [NUM_BUSES-1:0]   bus_valid;
    tag_t                   bus_tag [NUM_BUSES];
    data_t                  bus_data [NUM_BUSES];

    logic [NUM_ENTRIES-1:0] src1_valid;
    logic [NUM_ENTRIES-1:0] src2_valid;
    data_t                  src1_opd [NUM_ENTRIES];
    data_t                  src2_opd [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] grant;

    pc_t                    sel_pc;
    tag_t                   sel_rd;
    data_t                  sel_src1;
    data_t                  sel_src2;

    assign bus_valid[BUS_ALU]  = alu_valid;
    assign bus_valid[BUS_MUL]  = mul_valid;
    assign bus_valid[BUS_DIV]  = div_valid;
    assign bus_valid[BUS_LOAD] = load_valid;
    assign bus_tag[BUS_ALU]    = alu_dest;
    assign bus_tag[BUS_MUL]    = mul_dest;
    assign bus_tag[BUS_DIV]    = div_dest;
    assign bus_tag[BUS_LOAD]   = load_dest;
    assign bus_data[BUS_ALU]   = alu_result;
    assign bus_data[BUS_MUL]   = mul_result;
    assign bus_data[BUS_DIV]   = div_result;
    assign bus_data[BUS_LOAD]  = load_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tail <= '0;
        end else if (alloc) begin
            tail <= (tail == IDX_W'(NUM_ENTRIES - 1)) ? '0 : tail + 1'b1;   // wrap
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pc_q[tail] <= alloc_pc;
            rd_q[tail] <= alloc_rd;
        end
    end

    rs_operand_slot #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_src1 (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc),
        .alloc_index  (tail),
        .in_tag       (src1_tag),
        .in_data      (src1_data),
        .in_ready     (src1_ready),
        .bus_valid    (bus_valid),
        .bus_tag      (bus_tag),
        .bus_data     (bus_data),
        .clear        (grant),
        .operand_valid(src1_valid),
        .operand_data (src1_opd)
    );

    rs_operand_slot #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_src2 (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc),
        .alloc_index  (tail),
        .in_tag       (src2_tag),
        .in_data      (src2_data),
        .in_ready     (src2_ready),
        .bus_valid    (bus_valid),
        .bus_tag      (bus_tag),
        .bus_data     (bus_data),
        .clear        (grant),
        .operand_valid(src2_valid),
        .operand_data (src2_opd)
    );

    assign ready = src1_valid & src2_valid;

    rs_select #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_select (
        .ready(ready),
        .grant(grant)
    );

    // grant is one-hot, so at most one entry lands here
    always_comb begin
        sel_pc   = '0;
        sel_rd   = '0;
        sel_src1 = '0;
        sel_src2 = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (grant[i]) begin
                sel_pc   = pc_q[i];
                sel_rd   = rd_q[i];
                sel_src1 = src1_opd[i];
                sel_src2 = src2_opd[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            issue_pc   <= sel_pc;
            issue_rd   <= sel_rd;
            issue_src1 <= sel_src1;
            issue_src2 <= sel_src2;
        end
    end

endmodule

`default_nettype wire

//--- tb_mul_rs.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mul_rs import mul_rs_pkg::*; ();

    localparam int NUM_ENTRIES = 16;
    localparam int CLK_PERIOD  = 8;
    localparam int TRACE_LINES = 41;
    localparam int COLS        = 24;    // values per trace line
    localparam int TIMEOUT     = (TRACE_LINES + 20) * CLK_PERIOD;

    logic  clk         = 1'b0;
    logic  reset       = 1'b1;
    logic  alloc       = 1'b0;
    pc_t   alloc_pc    = '0;
    tag_t  alloc_rd    = '0;
    tag_t  src1_tag    = '0;
    data_t src1_data   = '0;
    logic  src1_ready  = 1'b0;
    tag_t  src2_tag    = '0;
    data_t src2_data   = '0;
    logic  src2_ready  = 1'b0;
    data_t alu_result  = '0;
    tag_t  alu_dest    = '0;
    logic  alu_valid   = 1'b0;
    data_t mul_result  = '0;
    tag_t  mul_dest    = '0;
    logic  mul_valid   = 1'b0;
    data_t div_result  = '0;
    tag_t  div_dest    = '0;
    logic  div_valid   = 1'b0;
    data_t load_result = '0;
    tag_t  load_dest   = '0;
    logic  load_valid  = 1'b0;

    logic  issue_valid;
    pc_t   issue_pc;
    tag_t  issue_rd;
    data_t issue_src1;
    data_t issue_src2;

    logic [31:0] trace_mem [TRACE_LINES * COLS];
    int          checks = 0;
    int          errors = 0;

    mul_rs #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_dut (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] field(input int n, input int c);
        return trace_mem[n * COLS + c];
    endfunction

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1:       return "idle_after_reset";
            2:       return "alloc_ready";
            3:       return "bus_wakeup";
            4:       return "invalid_bus";
            5:       return "alloc_bypass";
            6:       return "ordered_issue";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_line(input int n);
        logic [31:0] bus_valid;
        bus_valid   = field(n, 10);     // one bit per bus, package order
        alloc       = field(n, 1) != 0;
        alloc_pc    = field(n, 2);
        alloc_rd    = tag_t'(field(n, 3));
        src1_tag    = tag_t'(field(n, 4));
        src1_data   = field(n, 5);
        src1_ready  = field(n, 6) != 0;
        src2_tag    = tag_t'(field(n, 7));
        src2_data   = field(n, 8);
        src2_ready  = field(n, 9) != 0;
        alu_valid   = bus_valid[BUS_ALU];
        alu_dest    = tag_t'(field(n, 11));
        alu_result  = field(n, 12);
        mul_valid   = bus_valid[BUS_MUL];
        mul_dest    = tag_t'(field(n, 13));
        mul_result  = field(n, 14);
        div_valid   = bus_valid[BUS_DIV];
        div_dest    = tag_t'(field(n, 15));
        div_result  = field(n, 16);
        load_valid  = bus_valid[BUS_LOAD];
        load_dest   = tag_t'(field(n, 17));
        load_result = field(n, 18);
    endtask

    task automatic check_line(input int n);
        string prefix;
        prefix = $sformatf("%s line %0d", test_name(field(n, 0)), n);
        check_value({prefix, " issue_valid"}, field(n, 19), issue_valid);
        if (field(n, 19) != 0) begin    // fields only matter on an issue
            check_value({prefix, " issue_pc"}, field(n, 20), issue_pc);
            check_value({prefix, " issue_rd"}, field(n, 21), issue_rd);
            check_value({prefix, " issue_src1"}, field(n, 22), issue_src1);
            check_value({prefix, " issue_src2"}, field(n, 23), issue_src2);
        end
    endtask

    initial begin
        bit trace_ok;
        trace_ok = 1'b1;
        $readmemh("mul_rs_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0])) begin
            $display("the trace file mul_rs_trace.txt could not be read");
            errors++;
            trace_ok = 1'b0;
        end else if ($isunknown(trace_mem[TRACE_LINES * COLS - 1])) begin
            $display("the trace file mul_rs_trace.txt holds fewer than %0d lines",
                     TRACE_LINES);
            errors++;
            trace_ok = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (trace_ok) begin
            for (int n = 0; n < TRACE_LINES; n++) begin
                drive_line(n);
                @(posedge clk);
                #(CLK_PERIOD / 2 - 1);  // just before the next falling edge
                check_line(n);
                @(negedge clk);
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the trace did not finish within %0d ns", TIMEOUT);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- mul_rs_trace.txt
// id alloc pc rd  s1_tag s1_data s1_rdy  s2_tag s2_data s2_rdy  bus_valid (alu=1 mul=2 div=4 load=8)
// alu_dest alu_res  mul_dest mul_res  div_dest div_res  load_dest load_res  exp_valid pc rd src1 src2
1 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
1 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
2 1 100 40  0 11 1  0 22 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
2 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 100 40 11 22
2 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
3 1 104 41  a1 0 0  0 33 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
3 1 108 42  0 44 1  a2 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
3 1 10c 43  a3 0 0  0 55 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
3 1 110 44  0 66 1  a4 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
3 0 0 0  0 0 0  0 0 0  1  a1 1001  0 0  0 0  0 0  0 0 0 0 0
3 0 0 0  0 0 0  0 0 0  2  0 0  a2 2002  0 0  0 0  1 104 41 1001 33
3 0 0 0  0 0 0  0 0 0  4  0 0  0 0  a3 3003  0 0  1 108 42 44 2002
3 0 0 0  0 0 0  0 0 0  8  0 0  0 0  0 0  a4 4004  1 10c 43 3003 55
3 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 110 44 66 4004
3 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
4 1 114 45  b1 0 0  0 77 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
4 0 0 0  0 0 0  0 0 0  0  b1 dead  b1 beef  0 0  0 0  0 0 0 0 0
4 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
4 0 0 0  0 0 0  0 0 0  a  0 0  b1 5005  0 0  b1 9999  0 0 0 0 0
4 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 114 45 5005 77
4 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
5 1 118 46  c1 0 0  c2 0 0  5  c1 6006  0 0  c2 7007  0 0  0 0 0 0 0
5 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 118 46 6006 7007
5 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0
6 1 11c 47  0 a07 1  0 b07 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
6 1 120 48  0 a08 1  0 b08 1  0  0 0  0 0  0 0  0 0  1 11c 47 a07 b07
6 1 124 49  0 a09 1  0 b09 1  0  0 0  0 0  0 0  0 0  1 120 48 a08 b08
6 1 128 4a  0 a0a 1  0 b0a 1  0  0 0  0 0  0 0  0 0  1 124 49 a09 b09
6 1 12c 4b  0 a0b 1  0 b0b 1  0  0 0  0 0  0 0  0 0  1 128 4a a0a b0a
6 1 130 4c  0 a0c 1  0 b0c 1  0  0 0  0 0  0 0  0 0  1 12c 4b a0b b0b
6 1 134 4d  0 a0d 1  0 b0d 1  0  0 0  0 0  0 0  0 0  1 130 4c a0c b0c
6 1 138 4e  d1 0 0  0 b0e 1  0  0 0  0 0  0 0  0 0  1 134 4d a0d b0d
6 1 13c 4f  d1 0 0  0 b0f 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
6 1 140 50  d1 0 0  0 b00 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
6 1 144 51  d1 0 0  0 b01 1  0  0 0  0 0  0 0  0 0  0 0 0 0 0
6 0 0 0  0 0 0  0 0 0  8  0 0  0 0  0 0  d1 8008  0 0 0 0 0
6 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 140 50 8008 b00
6 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 144 51 8008 b01
6 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 138 4e 8008 b0e
6 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  1 13c 4f 8008 b0f
6 0 0 0  0 0 0  0 0 0  0  0 0  0 0  0 0  0 0  0 0 0 0 0

//--- list.f
mul_rs_pkg.sv
rs_select.sv
rs_operand_slot.sv
mul_rs.sv
tb_mul_rs.sv

//--- Bender.yml
package:
  name: mul_rs

sources:
  - mul_rs_pkg.sv
  - rs_select.sv
  - rs_operand_slot.sv
  - mul_rs.sv
  - target: test
    files:
      - tb_mul_rs.sv
